//--- mem_bus_pkg.sv
package mem_bus_pkg;

	// Memory bus field widths
	localparam int MEM_ADDR_W = 32; // Word address
	localparam int MEM_DATA_W = 64; // One beat
	localparam int MEM_LEN_W  = 4;  // Burst length minus one
	localparam int MEM_DID_W  = 4;

	// Ids this engine places on requests and expects back on responses
	localparam logic [MEM_DID_W-1:0] DMA_DID    = 4'h2;
	localparam logic [MEM_DID_W-1:0] DMA_SUBDID = 4'h5;

	// Burst shape
	localparam int BURST_LEN   = 8;
	localparam int BURST_SHIFT = $clog2(BURST_LEN); // Words to bursts

	// Outstanding requests the bus allows
	localparam int MEM_CREDITS = 2;
	localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

	// Response buffer
	localparam int FIFO_DEPTH = 32;
	localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
	localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1); // Holds 0 to FIFO_DEPTH

endpackage

//--- cfg_bus_pkg.sv
package cfg_bus_pkg;

	// Register bus widths
	localparam int CFG_ADDR_W = 4;
	localparam int CFG_DATA_W = 32;

	// Register map, low address bits only
	localparam logic [CFG_ADDR_W-1:0] REG_START  = 4'd0; // Start word address
	localparam logic [CFG_ADDR_W-1:0] REG_CTRL   = 4'd1; // Go bit and length
	localparam logic [CFG_ADDR_W-1:0] REG_STATUS = 4'd2; // Read only

	// Transfer length in words
	localparam int XFER_LEN_W = 16;

	// Unused bits between go and length in the control word
	localparam int CTRL_RSVD_W = CFG_DATA_W - 1 - XFER_LEN_W;

	// Status word is busy in bit 31, underrun in bit 30 and bursts left at the bottom
	localparam int STAT_RSVD_W = CFG_DATA_W - 2 - XFER_LEN_W;

	// One config data word, seen either as a start address or as the control view
	typedef union packed {
		logic [CFG_DATA_W-1:0] addr;
		struct packed {
			logic                   go;   // Bit 31
			logic [CTRL_RSVD_W-1:0] rsvd;
			logic [XFER_LEN_W-1:0]  len;  // Word count
		} ctrl;
	} cfg_word_u;

endpackage

//--- dma_cfg_regs.sv
`timescale 1ns/100ps

module dma_cfg_regs (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               cfg_valid,
	input  logic                               cfg_r_nw,
	input  logic [cfg_bus_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [cfg_bus_pkg::CFG_DATA_W-1:0] cfg_wdata,
	output logic                               cfg_rvalid,
	output logic [cfg_bus_pkg::CFG_DATA_W-1:0] cfg_rdata,
	input  logic                               busy,
	input  logic [cfg_bus_pkg::XFER_LEN_W-1:0] bursts_left,
	input  logic                               underrun,
	output logic                               start,
	output logic [mem_bus_pkg::MEM_ADDR_W-1:0] start_addr,
	output logic [cfg_bus_pkg::XFER_LEN_W-1:0] xfer_len
);
	import cfg_bus_pkg::*;

	cfg_word_u wr_word;
	cfg_word_u ctrl_view;
	logic      wr_en;
	logic      go_accept;
	logic      underrun_flag; // Sticky until the next accepted go

	assign wr_word = cfg_wdata;
	assign wr_en   = cfg_valid && !cfg_r_nw;

	// A go while a transfer runs is dropped
	assign go_accept = wr_en && (cfg_addr == REG_CTRL) && wr_word.ctrl.go && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			start_addr    <= '0;
			xfer_len      <= '0;
			start         <= 1'b0;
			underrun_flag <= 1'b0;
		end else begin
			start <= go_accept; // Pulse lands the cycle after the write
			if (wr_en && cfg_addr == REG_START)
				start_addr <= wr_word.addr;
			if (wr_en && cfg_addr == REG_CTRL)
				xfer_len <= wr_word.ctrl.len;
			if (go_accept)
				underrun_flag <= 1'b0;
			if (underrun)
				underrun_flag <= 1'b1; // A fresh underrun wins over the clear
		end
	end

	// Control readback, go reads as zero
	always_comb begin
		ctrl_view           = '0;
		ctrl_view.ctrl.len  = xfer_len;
	end

	always_ff @(posedge clk) begin
		if (reset)
			cfg_rvalid <= 1'b0;
		else
			cfg_rvalid <= cfg_valid && cfg_r_nw;
	end

	always_ff @(posedge clk) begin
		if (cfg_valid && cfg_r_nw) begin
			case (cfg_addr)
				REG_START:  cfg_rdata <= start_addr;
				REG_CTRL:   cfg_rdata <= ctrl_view.addr;
				REG_STATUS: cfg_rdata <= {busy, underrun_flag, {STAT_RSVD_W{1'b0}}, bursts_left};
				default:    cfg_rdata <= '0;
			endcase
		end
	end

	// Control must have gone idle before another start can reach it
	a_no_start_busy: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy)
		else $error("start pulse while busy");

endmodule

//--- dma_ctrl.sv
`timescale 1ns/100ps

module dma_ctrl (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               start,
	input  logic [mem_bus_pkg::MEM_ADDR_W-1:0] start_addr,
	input  logic [cfg_bus_pkg::XFER_LEN_W-1:0] xfer_len,
	input  logic                               credit_avail,
	input  logic [mem_bus_pkg::FIFO_CNT_W-1:0] fifo_count,
	input  logic                               beat_accept,
	output logic                               issue,
	output logic [mem_bus_pkg::MEM_ADDR_W-1:0] issue_addr,
	output logic                               busy,
	output logic [cfg_bus_pkg::XFER_LEN_W-1:0] bursts_left
);
	import mem_bus_pkg::*;
	import cfg_bus_pkg::*;

	localparam logic [1:0] IDLE  = 2'd0;
	localparam logic [1:0] ISSUE = 2'd1;
	localparam logic [1:0] DRAIN = 2'd2;

	logic [1:0]            state;
	logic [MEM_ADDR_W-1:0] next_addr;
	logic [FIFO_CNT_W-1:0] in_flight;     // Requested words not yet in the buffer
	logic [FIFO_CNT_W-1:0] in_flight_nxt;
	logic [FIFO_CNT_W:0]   room_need;     // One extra bit for the sum
	logic [XFER_LEN_W-1:0] burst_cnt;
	logic                  room_ok;
	logic                  issue_last;

	assign burst_cnt = xfer_len >> BURST_SHIFT; // Low bits of the length dropped

	// Buffered words plus words on the way plus one more burst must fit
	assign room_need = fifo_count + in_flight + (FIFO_CNT_W+1)'(BURST_LEN);
	assign room_ok   = room_need <= (FIFO_CNT_W+1)'(FIFO_DEPTH);

	assign issue      = (state == ISSUE) && credit_avail && !issue_last && room_ok;
	assign issue_addr = next_addr;
	assign busy       = (state != IDLE);

	always_comb begin
		in_flight_nxt = in_flight;
		if (issue)
			in_flight_nxt = in_flight_nxt + FIFO_CNT_W'(BURST_LEN);
		if (beat_accept)
			in_flight_nxt = in_flight_nxt - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			bursts_left <= '0;
			in_flight   <= '0;
			issue_last  <= 1'b0;
		end else begin
			issue_last <= issue; // Keeps bursts two cycles apart
			in_flight  <= in_flight_nxt;
			case (state)
				IDLE: begin
					if (start && burst_cnt != '0) begin
						bursts_left <= burst_cnt;
						state       <= ISSUE;
					end
				end
				ISSUE: begin
					if (issue) begin
						bursts_left <= bursts_left - 1'b1;
						if (bursts_left == XFER_LEN_W'(1))
							state <= DRAIN; // Last burst is out
					end
				end
				DRAIN: begin
					if (in_flight_nxt == '0)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address walks one burst per issue
	always_ff @(posedge clk) begin
		if (state == IDLE && start)
			next_addr <= start_addr;
		else if (issue)
			next_addr <= next_addr + MEM_ADDR_W'(BURST_LEN);
	end

	a_in_flight_max: assert property (@(posedge clk) disable iff (reset)
		in_flight <= FIFO_CNT_W'(FIFO_DEPTH))
		else $error("words in flight above buffer depth");

	// Words of every granted burst still on the way means no credit is left
	a_issue_credit: assert property (@(posedge clk) disable iff (reset)
		(in_flight > FIFO_CNT_W'((MEM_CREDITS - 1) * BURST_LEN)) |-> !credit_avail)
		else $error("credit still available with every burst in flight");

endmodule

//--- dma_req_issuer.sv
`timescale 1ns/100ps

module dma_req_issuer (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               issue,
	input  logic [mem_bus_pkg::MEM_ADDR_W-1:0] issue_addr,
	input  logic                               mem_credit,
	output logic                               credit_avail,
	output logic                               mem_req_valid,
	output logic [mem_bus_pkg::MEM_ADDR_W-1:0] mem_req_addr,
	output logic [mem_bus_pkg::MEM_LEN_W-1:0]  mem_req_len,
	output logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_req_did,
	output logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_req_subdid
);
	import mem_bus_pkg::*;

	logic [CREDIT_W-1:0] credit_cnt;

	assign credit_avail = (credit_cnt != '0);

	// Spend on issue, earn back on each returned credit
	always_ff @(posedge clk) begin
		if (reset) begin
			credit_cnt <= CREDIT_W'(MEM_CREDITS);
		end else begin
			case ({issue, mem_credit})
				2'b10:   credit_cnt <= credit_cnt - 1'b1;
				2'b01:   credit_cnt <= credit_cnt + 1'b1;
				default: credit_cnt <= credit_cnt; // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			mem_req_valid <= 1'b0;
		else
			mem_req_valid <= issue;
	end

	// Request fields, held until the next issue
	always_ff @(posedge clk) begin
		if (issue) begin
			mem_req_addr   <= issue_addr;
			mem_req_len    <= MEM_LEN_W'(BURST_LEN - 1);
			mem_req_did    <= DMA_DID;
			mem_req_subdid <= DMA_SUBDID;
		end
	end

	// Bus must not hand back more credits than it gave out
	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credit_cnt <= CREDIT_W'(MEM_CREDITS))
		else $error("credit count above MEM_CREDITS");

endmodule

//--- dma_resp_fifo.sv
`timescale 1ns/100ps

module dma_resp_fifo (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               mem_rsp_valid,
	input  logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_rsp_did,
	input  logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_rsp_subdid,
	input  logic [mem_bus_pkg::MEM_DATA_W-1:0] mem_rsp_data,
	output logic                               beat_accept,
	output logic [mem_bus_pkg::FIFO_CNT_W-1:0] fifo_count,
	input  logic                               rd_req,
	output logic                               rd_valid,
	output logic [mem_bus_pkg::MEM_DATA_W-1:0] rd_data,
	output logic                               underrun
);
	import mem_bus_pkg::*;

	logic [MEM_DATA_W-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic                  empty;
	logic                  full;
	logic                  pop;

	assign empty = (fifo_count == '0);
	assign full  = (fifo_count == FIFO_CNT_W'(FIFO_DEPTH));

	// Beats for other devices share the bus and are dropped here
	assign beat_accept = mem_rsp_valid && (mem_rsp_did == DMA_DID)
		&& (mem_rsp_subdid == DMA_SUBDID);

	assign pop      = rd_req && !empty;
	assign underrun = rd_req && empty; // Nothing to hand back

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_count <= '0;
			rd_valid   <= 1'b0;
		end else begin
			rd_valid <= pop;
			if (beat_accept)
				wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, wraps itself
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({beat_accept, pop})
				2'b10:   fifo_count <= fifo_count + 1'b1;
				2'b01:   fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (beat_accept)
			mem[wr_ptr] <= mem_rsp_data;
	end

	always_ff @(posedge clk) begin
		if (pop)
			rd_data <= mem[rd_ptr];
	end

	// Issue side keeps room for every requested beat
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		beat_accept |-> !full)
		else $error("beat accepted into a full buffer");

endmodule

//--- dma_read_top.sv
`timescale 1ns/100ps

module dma_read_top (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               cfg_valid,
	input  logic                               cfg_r_nw,
	input  logic [cfg_bus_pkg::CFG_ADDR_W-1:0] cfg_addr,
	input  logic [cfg_bus_pkg::CFG_DATA_W-1:0] cfg_wdata,
	output logic                               cfg_rvalid,
	output logic [cfg_bus_pkg::CFG_DATA_W-1:0] cfg_rdata,
	output logic                               mem_req_valid,
	output logic [mem_bus_pkg::MEM_ADDR_W-1:0] mem_req_addr,
	output logic [mem_bus_pkg::MEM_LEN_W-1:0]  mem_req_len,
	output logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_req_did,
	output logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_req_subdid,
	input  logic                               mem_credit,
	input  logic                               mem_rsp_valid,
	input  logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_rsp_did,
	input  logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_rsp_subdid,
	input  logic [mem_bus_pkg::MEM_DATA_W-1:0] mem_rsp_data,
	input  logic                               rd_req,
	output logic                               rd_valid,
	output logic [mem_bus_pkg::MEM_DATA_W-1:0] rd_data
);
	import mem_bus_pkg::*;
	import cfg_bus_pkg::*;

	logic                  start;
	logic [MEM_ADDR_W-1:0] start_addr;
	logic [XFER_LEN_W-1:0] xfer_len;
	logic                  busy;
	logic [XFER_LEN_W-1:0] bursts_left;
	logic                  underrun;
	logic                  issue;
	logic [MEM_ADDR_W-1:0] issue_addr;
	logic                  credit_avail;
	logic [FIFO_CNT_W-1:0] fifo_count;
	logic                  beat_accept;

	dma_cfg_regs u_dma_cfg_regs (
		.clk(clk), .reset(reset),
		.cfg_valid(cfg_valid), .cfg_r_nw(cfg_r_nw), .cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata), .cfg_rvalid(cfg_rvalid), .cfg_rdata(cfg_rdata),
		.busy(busy), .bursts_left(bursts_left), .underrun(underrun),
		.start(start), .start_addr(start_addr), .xfer_len(xfer_len)
	);

	dma_ctrl u_dma_ctrl (
		.clk(clk), .reset(reset),
		.start(start), .start_addr(start_addr), .xfer_len(xfer_len),
		.credit_avail(credit_avail), .fifo_count(fifo_count), .beat_accept(beat_accept),
		.issue(issue), .issue_addr(issue_addr), .busy(busy), .bursts_left(bursts_left)
	);

	dma_req_issuer u_dma_req_issuer (
		.clk(clk), .reset(reset),
		.issue(issue), .issue_addr(issue_addr), .mem_credit(mem_credit),
		.credit_avail(credit_avail), .mem_req_valid(mem_req_valid),
		.mem_req_addr(mem_req_addr), .mem_req_len(mem_req_len),
		.mem_req_did(mem_req_did), .mem_req_subdid(mem_req_subdid)
	);

	dma_resp_fifo u_dma_resp_fifo (
		.clk(clk), .reset(reset),
		.mem_rsp_valid(mem_rsp_valid), .mem_rsp_did(mem_rsp_did),
		.mem_rsp_subdid(mem_rsp_subdid), .mem_rsp_data(mem_rsp_data),
		.beat_accept(beat_accept), .fifo_count(fifo_count),
		.rd_req(rd_req), .rd_valid(rd_valid), .rd_data(rd_data), .underrun(underrun)
	);

endmodule

//--- tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               mem_req_valid,
	input  logic [mem_bus_pkg::MEM_ADDR_W-1:0] mem_req_addr,
	output logic                               mem_credit,
	output logic                               mem_rsp_valid,
	output logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_rsp_did,
	output logic [mem_bus_pkg::MEM_DID_W-1:0]  mem_rsp_subdid,
	output logic [mem_bus_pkg::MEM_DATA_W-1:0] mem_rsp_data
);
	import mem_bus_pkg::*;

	localparam int RSP_DELAY = 6; // Request to first beat, in cycles

	logic [MEM_ADDR_W-1:0] addr_q [$];
	int                    due_q [$];
	logic [MEM_ADDR_W-1:0] burst_addr;
	int                    cycle = 0;
	int                    beat_idx = 0;  // -1 marks the foreign beat
	int                    burst_num = 0;
	bit                    active = 1'b0;
	bit                    credit_due = 1'b0;

	function automatic logic [MEM_DATA_W-1:0] memory_word(input logic [MEM_ADDR_W-1:0] a);
		return {~a, a};
	endfunction

	initial begin
		mem_credit     = 1'b0;
		mem_rsp_valid  = 1'b0;
		mem_rsp_did    = '0;
		mem_rsp_subdid = '0;
		mem_rsp_data   = '0;
		forever begin
			@(negedge clk);
			cycle++;
			if (!reset && mem_req_valid) begin
				addr_q.push_back(mem_req_addr);
				due_q.push_back(cycle + RSP_DELAY);
			end
			@(posedge clk);
			#1;
			mem_rsp_valid = 1'b0;
			mem_credit    = credit_due; // One cycle after the last beat
			credit_due    = 1'b0;
			if (!active && addr_q.size() != 0 && cycle >= due_q[0]) begin
				burst_addr = addr_q.pop_front();
				void'(due_q.pop_front());
				beat_idx   = (burst_num % 2 == 1) ? -1 : 0;
				burst_num++;
				active     = 1'b1;
			end
			if (active) begin
				mem_rsp_valid  = 1'b1;
				mem_rsp_did    = DMA_DID;
				// Foreign beat carries real looking data so a wrong accept shows up
				mem_rsp_subdid = (beat_idx < 0) ? ~DMA_SUBDID : DMA_SUBDID;
				mem_rsp_data   = memory_word(burst_addr + MEM_ADDR_W'(beat_idx < 0 ? 0 : beat_idx));
				beat_idx++;
				if (beat_idx == BURST_LEN) begin
					active     = 1'b0;
					credit_due = 1'b1;
				end
			end
		end
	end

endmodule

//--- tb_dma_read.sv
`timescale 1ns/100ps

module tb_dma_read;
	import mem_bus_pkg::*;
	import cfg_bus_pkg::*;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  cfg_valid;
	logic                  cfg_r_nw;
	logic [CFG_ADDR_W-1:0] cfg_addr;
	logic [CFG_DATA_W-1:0] cfg_wdata;
	logic                  cfg_rvalid;
	logic [CFG_DATA_W-1:0] cfg_rdata;
	logic                  mem_req_valid;
	logic [MEM_ADDR_W-1:0] mem_req_addr;
	logic [MEM_LEN_W-1:0]  mem_req_len;
	logic [MEM_DID_W-1:0]  mem_req_did;
	logic [MEM_DID_W-1:0]  mem_req_subdid;
	logic                  mem_credit;
	logic                  mem_rsp_valid;
	logic [MEM_DID_W-1:0]  mem_rsp_did;
	logic [MEM_DID_W-1:0]  mem_rsp_subdid;
	logic [MEM_DATA_W-1:0] mem_rsp_data;
	logic                  rd_req;
	logic                  rd_valid;
	logic [MEM_DATA_W-1:0] rd_data;

	// Stimulus table, one column per array: start address, words, random gaps, bursts
	logic [MEM_ADDR_W-1:0] row_addr [5] = '{32'h0000_1000, 32'h0000_2040, 32'h00ab_0000,
		32'hffff_ff00, 32'h0000_0100};
	int                    row_len [5] = '{32, 64, 20, 16, 8};
	bit                    row_rand [5] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0};
	int                    row_bursts [5] = '{4, 8, 2, 2, 1}; // Low length bits dropped

	integer                seed = 32'h3f30_3261;
	int                    cycle_cnt = 0;
	int                    cycle_limit = 500;
	int                    mismatch_cnt = 0;
	int                    other_cnt = 0;
	logic [MEM_ADDR_W-1:0] cur_addr;
	int                    exp_words;
	int                    words_seen;
	int                    reqs_seen;
	int                    outstanding = 0; // Requests not yet paid back by a credit
	logic [CFG_DATA_W-1:0] status;

	always #4 clk = ~clk;

	dma_read_top u_dma_read_top (
		.clk(clk), .reset(reset),
		.cfg_valid(cfg_valid), .cfg_r_nw(cfg_r_nw), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_rvalid(cfg_rvalid), .cfg_rdata(cfg_rdata),
		.mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr), .mem_req_len(mem_req_len),
		.mem_req_did(mem_req_did), .mem_req_subdid(mem_req_subdid), .mem_credit(mem_credit),
		.mem_rsp_valid(mem_rsp_valid), .mem_rsp_did(mem_rsp_did),
		.mem_rsp_subdid(mem_rsp_subdid), .mem_rsp_data(mem_rsp_data),
		.rd_req(rd_req), .rd_valid(rd_valid), .rd_data(rd_data)
	);

	tb_mem_model u_mem_model (
		.clk(clk), .reset(reset),
		.mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr), .mem_credit(mem_credit),
		.mem_rsp_valid(mem_rsp_valid), .mem_rsp_did(mem_rsp_did),
		.mem_rsp_subdid(mem_rsp_subdid), .mem_rsp_data(mem_rsp_data)
	);

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: transfers did not complete within %0d cycles", cycle_limit);
			$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt + 1);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	function automatic logic [MEM_DATA_W-1:0] memory_word(input logic [MEM_ADDR_W-1:0] a);
		return {~a, a}; // Inverted address on top
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		mismatch_cnt++;
		$display("ERROR at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
	endtask

	task automatic report_failure(input string what);
		other_cnt++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	// Bus monitor, runs once per cycle at the falling edge
	task automatic sample_outputs;
		logic [MEM_ADDR_W-1:0] exp_req_addr;
		exp_req_addr = cur_addr + MEM_ADDR_W'(reqs_seen * BURST_LEN);
		if (rd_valid) begin
			if (words_seen >= exp_words)
				report_failure("rd_valid with no word left to deliver");
			else if (rd_data !== memory_word(cur_addr + MEM_ADDR_W'(words_seen)))
				report_mismatch("rd_data", rd_data, memory_word(cur_addr + MEM_ADDR_W'(words_seen)));
			words_seen++;
		end
		if (mem_req_valid) begin
			if (mem_req_addr !== exp_req_addr)
				report_mismatch("mem_req_addr", 64'(mem_req_addr), 64'(exp_req_addr));
			if (mem_req_len !== MEM_LEN_W'(BURST_LEN - 1))
				report_mismatch("mem_req_len", 64'(mem_req_len), 64'(BURST_LEN - 1));
			if (mem_req_did !== DMA_DID)
				report_mismatch("mem_req_did", 64'(mem_req_did), 64'(DMA_DID));
			if (mem_req_subdid !== DMA_SUBDID)
				report_mismatch("mem_req_subdid", 64'(mem_req_subdid), 64'(DMA_SUBDID));
			reqs_seen++;
			outstanding++;
		end
		if (mem_credit)
			outstanding--;
		if (outstanding > MEM_CREDITS)
			report_failure("more requests outstanding than the bus has credits");
	endtask

	task automatic next_cycle;
		@(negedge clk);
		sample_outputs();
		@(posedge clk);
		#1;
	endtask

	task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
		cfg_valid = 1'b1;
		cfg_r_nw  = 1'b0;
		cfg_addr  = addr;
		cfg_wdata = data;
		next_cycle();
		cfg_valid = 1'b0;
	endtask

	task automatic read_status;
		cfg_valid = 1'b1;
		cfg_r_nw  = 1'b1;
		cfg_addr  = REG_STATUS;
		next_cycle();
		cfg_valid = 1'b0;
		if (!cfg_rvalid)
			report_failure("no cfg_rvalid one cycle after a status read");
		status = cfg_rdata;
	endtask

	task automatic run_row(input int r);
		int gap;
		cur_addr   = row_addr[r];
		exp_words  = row_bursts[r] * BURST_LEN;
		words_seen = 0;
		reqs_seen  = 0;
		cfg_write(REG_START, row_addr[r]);
		cfg_write(REG_CTRL, {1'b1, 15'd0, 16'(row_len[r])}); // Go in bit 31
		next_cycle(); // Start pulse reaches the FSM
		read_status();
		if (status[31] !== 1'b1)
			report_mismatch("status busy", 64'(status[31]), 64'd1);
		if (status[30] !== 1'b0)
			report_mismatch("status underrun", 64'(status[30]), 64'd0);
		if (status[15:0] !== 16'(row_bursts[r]))
			report_mismatch("status bursts_left", 64'(status[15:0]), 64'(row_bursts[r]));
		while (words_seen < exp_words) begin
			rd_req = 1'b1;
			next_cycle();
			rd_req = 1'b0;
			if (row_rand[r]) begin
				gap = $random(seed) & 3;
				repeat (gap) next_cycle();
			end
		end
		next_cycle();
		read_status();
		if (status[31] !== 1'b0)
			report_mismatch("status busy", 64'(status[31]), 64'd0);
		if (status[15:0] !== 16'd0)
			report_mismatch("status bursts_left", 64'(status[15:0]), 64'd0);
		if (reqs_seen != row_bursts[r])
			report_mismatch("mem_req_valid count", 64'(reqs_seen), 64'(row_bursts[r]));
	endtask

	initial begin
		reset     = 1'b1;
		cfg_valid = 1'b0;
		cfg_r_nw  = 1'b0;
		cfg_addr  = '0;
		cfg_wdata = '0;
		rd_req    = 1'b0;
		cur_addr  = '0;
		exp_words = 0;
		words_seen = 0;
		reqs_seen = 0;
		for (int i = 0; i < 5; i++)
			cycle_limit += row_len[i] * 20;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// Pull from the empty buffer before any transfer
		rd_req = 1'b1;
		next_cycle();
		rd_req = 1'b0;
		next_cycle();
		read_status();
		if (status[30] !== 1'b1)
			report_mismatch("status underrun", 64'(status[30]), 64'd1);
		if (status[31] !== 1'b0)
			report_mismatch("status busy", 64'(status[31]), 64'd0);

		for (int r = 0; r < 5; r++)
			run_row(r);

		$display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- flist.f
mem_bus_pkg.sv
cfg_bus_pkg.sv
dma_cfg_regs.sv
dma_ctrl.sv
dma_req_issuer.sv
dma_resp_fifo.sv
dma_read_top.sv
tb_mem_model.sv
tb_dma_read.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, then judge the log
rm -rf obj_dir sim.log
verilator --binary --assert -f flist.f --top-module tb_dma_read -o tb_dma_read \
	&& ./obj_dir/tb_dma_read > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && { echo "Result: failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "Result: no verdict in log"; exit 1; }
echo "Result: passed"
exit 0
